//--- src/bp_config_pkg.sv
package bp_config_pkg;

    localparam int PC_W       = 32;
    localparam int HIST_IDX_W = 8;            // BHT index, PC[9:2]
    localparam int HIST_W     = 10;           // Local history, also PHT index
    localparam int BTB_IDX_W  = 7;            // BTB index, PC[8:2]
    localparam int TAG_W      = PC_W - 2;     // PC[31:2]
    localparam int TGT_W      = PC_W - 1;     // Target[31:1], halfword aligned

    localparam int HIST_DEPTH = 1 << HIST_IDX_W;
    localparam int PHT_DEPTH  = 1 << HIST_W;
    localparam int BTB_DEPTH  = 1 << BTB_IDX_W;

    // Upper bit set means predict taken
    typedef enum logic [1:0] {
        strong_not_taken = 2'd0,
        weak_not_taken   = 2'd1,
        weak_taken       = 2'd2,
        strong_taken     = 2'd3
    } ctr_state_e;

endpackage

//--- src/bp_types_pkg.sv
package bp_types_pkg;

    import bp_config_pkg::*;

    // Fetch side request
    typedef struct packed {
        logic [PC_W-1:0] pc;
    } bp_lookup_t;

    typedef struct packed {
        logic [PC_W-1:0] pc;        // PC that was looked up
        logic            taken;
        logic [PC_W-1:0] target;    // BTB target or PC+4
    } bp_prediction_t;

    // Resolved branch from execute
    typedef struct packed {
        logic [PC_W-1:0] pc;
        logic            taken;
        logic [PC_W-1:0] target;
    } bp_update_t;

endpackage

//--- src/bp_history_table.sv
`timescale 1ns/1ps

module bp_history_table #(
    parameter int ENTRIES = bp_config_pkg::HIST_DEPTH,
    parameter int WIDTH = bp_config_pkg::HIST_W,
    localparam int IDX_W = $clog2(ENTRIES)
) (
    input  logic             clk_i,
    input  logic             rst_i,

    input  logic [IDX_W-1:0] lookup_idx_i,
    output logic [WIDTH-1:0] lookup_hist_o,

    input  logic [IDX_W-1:0] update_idx_i,
    output logic [WIDTH-1:0] update_hist_o,
    input  logic             wen_i,
    input  logic [WIDTH-1:0] wdata_i
);

    logic [ENTRIES-1:0][WIDTH-1:0] hist_q;

    // Two async read ports, like the distributed RAM it replaces
    assign lookup_hist_o = hist_q[lookup_idx_i];
    assign update_hist_o = hist_q[update_idx_i];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hist_q <= '0;
        end else if (wen_i) begin
            hist_q[update_idx_i] <= wdata_i;
        end
    end

endmodule

//--- src/bp_pattern_table.sv
`timescale 1ns/1ps

module bp_pattern_table #(
    parameter int ENTRIES = bp_config_pkg::PHT_DEPTH,
    localparam int IDX_W = $clog2(ENTRIES)
) (
    input  logic             clk_i,
    input  logic             rst_i,

    input  logic [IDX_W-1:0] lookup_idx_i,
    output logic             lookup_taken_o,

    input  logic             wen_i,
    input  logic [IDX_W-1:0] update_idx_i,
    input  logic             outcome_i
);

    import bp_config_pkg::*;

    ctr_state_e [ENTRIES-1:0] ctr_q;
    ctr_state_e               ctr_cur;
    ctr_state_e               ctr_next;
    logic [1:0]               lookup_ctr;

    assign lookup_ctr     = ctr_q[lookup_idx_i];
    assign lookup_taken_o = lookup_ctr[1];

    assign ctr_cur = ctr_q[update_idx_i];

    // Saturating step toward the outcome
    always_comb begin
        ctr_next = ctr_cur;
        unique case (ctr_cur)
            strong_not_taken: ctr_next = outcome_i ? weak_not_taken : strong_not_taken;
            weak_not_taken:   ctr_next = outcome_i ? weak_taken : strong_not_taken;
            weak_taken:       ctr_next = outcome_i ? strong_taken : weak_not_taken;
            strong_taken:     ctr_next = outcome_i ? strong_taken : weak_taken;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < ENTRIES; i++) begin
                ctr_q[i] <= strong_not_taken;
            end
        end else if (wen_i) begin
            ctr_q[update_idx_i] <= ctr_next;
        end
    end

endmodule

//--- src/bp_target_buffer.sv
`timescale 1ns/1ps

module bp_target_buffer #(
    parameter int ENTRIES = bp_config_pkg::BTB_DEPTH
) (
    input  logic                        clk_i,
    input  logic                        rst_i,

    input  logic [bp_config_pkg::PC_W-1:0] lookup_pc_i,
    output logic                        hit_o,
    output logic [bp_config_pkg::PC_W-1:0] target_o,

    input  logic                        wen_i,
    input  logic [bp_config_pkg::PC_W-1:0] update_pc_i,
    input  logic [bp_config_pkg::PC_W-1:0] update_target_i
);

    import bp_config_pkg::*;

    localparam int IDX_W = $clog2(ENTRIES);

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [TGT_W-1:0] target;
    } btb_entry_t;

    btb_entry_t       entry_q [ENTRIES];
    logic [ENTRIES-1:0] valid_q;

    logic [IDX_W-1:0] lookup_idx;
    logic [IDX_W-1:0] update_idx;
    btb_entry_t       lookup_entry;
    btb_entry_t       update_entry;

    assign lookup_idx = lookup_pc_i[IDX_W+1:2];
    assign update_idx = update_pc_i[IDX_W+1:2];

    assign lookup_entry = entry_q[lookup_idx];

    assign hit_o    = valid_q[lookup_idx] && (lookup_entry.tag == lookup_pc_i[PC_W-1:2]);
    assign target_o = {lookup_entry.target, 1'b0};

    assign update_entry.tag    = update_pc_i[PC_W-1:2];
    assign update_entry.target = update_target_i[PC_W-1:1]; // Bit 0 always zero

    always_ff @(posedge clk_i) begin
        if (wen_i) begin
            entry_q[update_idx] <= update_entry;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (wen_i) begin
            valid_q[update_idx] <= 1'b1;
        end
    end

endmodule

//--- src/bp_lookup_stage.sv
`timescale 1ns/1ps

module bp_lookup_stage (
    input  logic                              clk_i,
    input  logic                              rst_i,

    input  logic                              lookup_valid_i,
    input  bp_types_pkg::bp_lookup_t          lookup_i,
    output logic                              lookup_ready_o,

    output logic [bp_config_pkg::HIST_IDX_W-1:0] hist_idx_o,
    input  logic [bp_config_pkg::HIST_W-1:0]  hist_i,
    output logic [bp_config_pkg::HIST_W-1:0]  ctr_idx_o,
    input  logic                              ctr_taken_i,
    output logic [bp_config_pkg::PC_W-1:0]    btb_pc_o,
    input  logic                              btb_hit_i,
    input  logic [bp_config_pkg::PC_W-1:0]    btb_target_i,

    output logic                              pred_valid_o,
    output bp_types_pkg::bp_prediction_t      pred_o,
    input  logic                              pred_ready_i
);

    import bp_config_pkg::*;
    import bp_types_pkg::*;

    bp_prediction_t pred_next;
    bp_prediction_t pred_q;
    logic           pred_valid_q;

    assign hist_idx_o = lookup_i.pc[HIST_IDX_W+1:2];
    assign ctr_idx_o  = hist_i;                 // Local history selects the counter
    assign btb_pc_o   = lookup_i.pc;

    // Taken needs both a taken counter and a BTB hit
    assign pred_next.pc     = lookup_i.pc;
    assign pred_next.taken  = ctr_taken_i && btb_hit_i;
    assign pred_next.target = pred_next.taken ? btb_target_i : lookup_i.pc + PC_W'(4);

    assign lookup_ready_o = !pred_valid_q || pred_ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pred_valid_q <= 1'b0;
        end else if (lookup_ready_o) begin
            pred_valid_q <= lookup_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (lookup_ready_o && lookup_valid_i) begin
            pred_q <= pred_next;
        end
    end

    assign pred_valid_o = pred_valid_q;
    assign pred_o       = pred_q;

endmodule

//--- src/bp_update_stage.sv
`timescale 1ns/1ps

module bp_update_stage (
    input  logic                              clk_i,
    input  logic                              rst_i,

    input  logic                              update_valid_i,
    input  bp_types_pkg::bp_update_t          update_i,

    output logic [bp_config_pkg::HIST_IDX_W-1:0] hist_idx_o,
    input  logic [bp_config_pkg::HIST_W-1:0]  hist_i,
    output logic                              wen_o,
    output logic [bp_config_pkg::HIST_W-1:0]  hist_wdata_o,
    output logic [bp_config_pkg::HIST_W-1:0]  ctr_idx_o,
    output logic                              outcome_o,
    output logic [bp_config_pkg::PC_W-1:0]    btb_pc_o,
    output logic [bp_config_pkg::PC_W-1:0]    btb_target_o
);

    import bp_config_pkg::*;
    import bp_types_pkg::*;

    bp_update_t upd_q;
    logic       upd_valid_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            upd_valid_q <= 1'b0;
        end else begin
            upd_valid_q <= update_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (update_valid_i) begin
            upd_q <= update_i;
        end
    end

    // Write back one cycle after capture
    assign wen_o      = upd_valid_q;
    assign hist_idx_o = upd_q.pc[HIST_IDX_W+1:2];

    // Old history picks the counter, new history shifts in the outcome
    assign ctr_idx_o    = hist_i;
    assign hist_wdata_o = {hist_i[HIST_W-2:0], upd_q.taken};
    assign outcome_o    = upd_q.taken;

    assign btb_pc_o     = upd_q.pc;
    assign btb_target_o = upd_q.target;

endmodule

//--- src/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor #(
    parameter int HIST_ENTRIES = bp_config_pkg::HIST_DEPTH,
    parameter int PHT_ENTRIES = bp_config_pkg::PHT_DEPTH,
    parameter int BTB_ENTRIES = bp_config_pkg::BTB_DEPTH
) (
    input  logic                         clk_i,
    input  logic                         rst_i,

    input  logic                         lookup_valid_i,
    input  bp_types_pkg::bp_lookup_t     lookup_i,
    output logic                         lookup_ready_o,

    output logic                         pred_valid_o,
    output bp_types_pkg::bp_prediction_t pred_o,
    input  logic                         pred_ready_i,

    input  logic                         update_valid_i,
    input  bp_types_pkg::bp_update_t     update_i
);

    import bp_config_pkg::*;

    // Lookup side
    logic [HIST_IDX_W-1:0] lk_hist_idx;
    logic [HIST_W-1:0]     lk_hist;
    logic [HIST_W-1:0]     lk_ctr_idx;
    logic                  lk_ctr_taken;
    logic [PC_W-1:0]       lk_btb_pc;
    logic                  lk_btb_hit;
    logic [PC_W-1:0]       lk_btb_target;

    // Update side
    logic [HIST_IDX_W-1:0] up_hist_idx;
    logic [HIST_W-1:0]     up_hist;
    logic                  up_wen;
    logic [HIST_W-1:0]     up_hist_wdata;
    logic [HIST_W-1:0]     up_ctr_idx;
    logic                  up_outcome;
    logic [PC_W-1:0]       up_btb_pc;
    logic [PC_W-1:0]       up_btb_target;

    bp_history_table #(
        .ENTRIES(HIST_ENTRIES),
        .WIDTH  (HIST_W)
    ) u_history_table (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .lookup_idx_i (lk_hist_idx),
        .lookup_hist_o(lk_hist),
        .update_idx_i (up_hist_idx),
        .update_hist_o(up_hist),
        .wen_i        (up_wen),
        .wdata_i      (up_hist_wdata)
    );

    bp_pattern_table #(
        .ENTRIES(PHT_ENTRIES)
    ) u_pattern_table (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .lookup_idx_i  (lk_ctr_idx),
        .lookup_taken_o(lk_ctr_taken),
        .wen_i         (up_wen),
        .update_idx_i  (up_ctr_idx),
        .outcome_i     (up_outcome)
    );

    bp_target_buffer #(
        .ENTRIES(BTB_ENTRIES)
    ) u_target_buffer (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .lookup_pc_i    (lk_btb_pc),
        .hit_o          (lk_btb_hit),
        .target_o       (lk_btb_target),
        .wen_i          (up_wen),
        .update_pc_i    (up_btb_pc),
        .update_target_i(up_btb_target)
    );

    bp_lookup_stage u_lookup_stage (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .lookup_valid_i(lookup_valid_i),
        .lookup_i      (lookup_i),
        .lookup_ready_o(lookup_ready_o),
        .hist_idx_o    (lk_hist_idx),
        .hist_i        (lk_hist),
        .ctr_idx_o     (lk_ctr_idx),
        .ctr_taken_i   (lk_ctr_taken),
        .btb_pc_o      (lk_btb_pc),
        .btb_hit_i     (lk_btb_hit),
        .btb_target_i  (lk_btb_target),
        .pred_valid_o  (pred_valid_o),
        .pred_o        (pred_o),
        .pred_ready_i  (pred_ready_i)
    );

    bp_update_stage u_update_stage (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .update_valid_i(update_valid_i),
        .update_i      (update_i),
        .hist_idx_o    (up_hist_idx),
        .hist_i        (up_hist),
        .wen_o         (up_wen),
        .hist_wdata_o  (up_hist_wdata),
        .ctr_idx_o     (up_ctr_idx),
        .outcome_o     (up_outcome),
        .btb_pc_o      (up_btb_pc),
        .btb_target_o  (up_btb_target)
    );

endmodule

//--- test/bp_checker.sv
`timescale 1ns/1ps

module bp_checker (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         lookup_valid_i,
    input  bp_types_pkg::bp_lookup_t     lookup_i,
    input  logic                         lookup_ready_i,
    input  logic                         pred_valid_i,
    input  bp_types_pkg::bp_prediction_t pred_i,
    input  logic                         pred_ready_i,
    input  logic                         update_valid_i,
    input  bp_types_pkg::bp_update_t     update_i,
    input  int                           test_i,
    input  int                           num_vectors_i,
    input  logic                         done_i,
    output int                           error_count_o,
    output int                           pending_o,
    output logic                         timed_out_o
);

    import bp_config_pkg::*;
    import bp_types_pkg::*;

    // Table model
    logic [HIST_W-1:0] hist_m [HIST_DEPTH];
    logic [1:0]        ctr_m [PHT_DEPTH];
    logic              btb_valid_m [BTB_DEPTH];
    logic [TAG_W-1:0]  btb_tag_m [BTB_DEPTH];
    logic [PC_W-1:0]   btb_target_m [BTB_DEPTH];

    bp_prediction_t expect_q [$];
    bp_prediction_t held_pred;
    logic           held = 1'b0;
    logic           accepted_last = 1'b0;
    logic           summary_done = 1'b0;
    int             cycles = 0;
    int             last_test = 0;
    int             test_checks = 0;
    int             test_errors = 0;
    int             total_checks = 0;
    int             tests_done = 0;

    initial begin
        error_count_o = 0;
        pending_o = 0;
        timed_out_o = 1'b0;
    end

    function automatic bp_prediction_t predict(input logic [PC_W-1:0] pc);
        bp_prediction_t       p;
        logic [HIST_W-1:0]    h;
        logic [BTB_IDX_W-1:0] b;
        h = hist_m[pc[HIST_IDX_W+1:2]];
        b = pc[BTB_IDX_W+1:2];
        p.pc = pc;
        p.taken = ctr_m[h] >= 2'd2 && btb_valid_m[b] && btb_tag_m[b] == pc[PC_W-1:2];
        p.target = p.taken ? btb_target_m[b] : pc + 4;
        return p;
    endfunction

    task automatic train(input bp_update_t u);
        logic [HIST_W-1:0]    old;
        logic [BTB_IDX_W-1:0] b;
        old = hist_m[u.pc[HIST_IDX_W+1:2]];
        if (u.taken && ctr_m[old] != 2'd3) begin
            ctr_m[old] = ctr_m[old] + 2'd1;
        end else if (!u.taken && ctr_m[old] != 2'd0) begin
            ctr_m[old] = ctr_m[old] - 2'd1;
        end
        hist_m[u.pc[HIST_IDX_W+1:2]] = {old[HIST_W-2:0], u.taken};
        b = u.pc[BTB_IDX_W+1:2];
        btb_valid_m[b] = 1'b1;
        btb_tag_m[b] = u.pc[PC_W-1:2];
        btb_target_m[b] = {u.target[PC_W-1:1], 1'b0};
    endtask

    task automatic clear_model();
        for (int i = 0; i < HIST_DEPTH; i++) hist_m[i] = '0;
        for (int i = 0; i < PHT_DEPTH; i++) ctr_m[i] = 2'd0;
        for (int i = 0; i < BTB_DEPTH; i++) btb_valid_m[i] = 1'b0;
        expect_q.delete();
        held = 1'b0;
        accepted_last = 1'b0;
    endtask

    task automatic report_mismatch(input string name, input logic [PC_W-1:0] got,
                                   input logic [PC_W-1:0] exp_val);
        $display("Fail %s: got %h, expected %h (test %0d)", name, got, exp_val, last_test);
        test_errors++;
        error_count_o++;
    endtask

    task automatic note_error(input string msg);
        $display("Error in test %0d: %s", last_test, msg);
        test_errors++;
        error_count_o++;
    endtask

    task automatic compare(input bp_prediction_t exp_p, input bp_prediction_t got);
        test_checks++;
        total_checks++;
        if (got.pc !== exp_p.pc) begin
            report_mismatch("pred_o.pc", got.pc, exp_p.pc);
        end
        if (got.taken !== exp_p.taken) begin
            report_mismatch("pred_o.taken", got.taken, exp_p.taken);
        end
        if (got.target !== exp_p.target) begin
            report_mismatch("pred_o.target", got.target, exp_p.target);
        end
    endtask

    task automatic finish_test();
        $display("test %0d done: %0d checks, %0d errors", last_test, test_checks, test_errors);
        tests_done++;
        test_checks = 0;
        test_errors = 0;
    endtask

    always @(posedge clk_i) begin
        cycles++;
        if (!timed_out_o && cycles > num_vectors_i * 20 + 100) begin
            $display("Timeout: the run did not finish within %0d cycles",
                     num_vectors_i * 20 + 100);
            timed_out_o = 1'b1;
        end
        if (rst_i) begin
            clear_model();
        end else if (done_i) begin
            if (!summary_done) begin
                if (expect_q.size() != 0) note_error("some lookups never got a prediction");
                if (total_checks == 0) note_error("no prediction was checked");
                if (last_test != 0) finish_test();
                $display("Tests: %0d, checks: %0d, errors: %0d",
                         tests_done, total_checks, error_count_o);
                summary_done = 1'b1;
            end
        end else begin
            if (test_i != last_test) begin
                if (last_test != 0) finish_test();
                last_test = test_i;
            end
            if (lookup_ready_i !== (!pred_valid_i || pred_ready_i)) begin
                note_error("lookup_ready_o does not match the output register state");
            end
            // One cycle lookup latency
            if (accepted_last && pred_valid_i !== 1'b1) begin
                note_error("no prediction one cycle after an accepted lookup");
            end
            accepted_last = lookup_valid_i && lookup_ready_i;
            // Stalled output must not move
            if (held && !pred_valid_i) note_error("pred_valid_o dropped before acceptance");
            else if (held && pred_i !== held_pred) note_error("pred_o changed while stalled");
            held = pred_valid_i && !pred_ready_i;
            held_pred = pred_i;
            if (pred_valid_i && pred_ready_i) begin
                if (expect_q.size() == 0) note_error("prediction came with no pending lookup");
                else compare(expect_q.pop_front(), pred_i);
            end
            if (lookup_valid_i && lookup_ready_i) expect_q.push_back(predict(lookup_i.pc));
            if (update_valid_i) train(update_i);
        end
        pending_o = expect_q.size();
    end

endmodule

//--- test/tb_branch_predictor.sv
`timescale 1ns/1ps

module tb_branch_predictor;

    import bp_config_pkg::*;
    import bp_types_pkg::*;

    localparam int MAX_VEC = 64;
    localparam int VEC_W   = 80;    // op, pc, outcome, target, test

    logic           clk = 1'b0;
    logic           rst;
    logic           lookup_valid;
    bp_lookup_t     lookup;
    logic           lookup_ready;
    logic           pred_valid;
    bp_prediction_t pred;
    logic           pred_ready;
    logic           update_valid;
    bp_update_t     update;

    logic [VEC_W-1:0] vec_mem [MAX_VEC];
    int               num_vec;
    int               cur_test;
    int               stall_left;
    int               seed;
    logic             prev_update;
    logic             done;
    int               error_count;
    int               pending;
    logic             timed_out;

    always #20 clk = ~clk;

    branch_predictor u_branch_predictor (
        .clk_i         (clk),
        .rst_i         (rst),
        .lookup_valid_i(lookup_valid),
        .lookup_i      (lookup),
        .lookup_ready_o(lookup_ready),
        .pred_valid_o  (pred_valid),
        .pred_o        (pred),
        .pred_ready_i  (pred_ready),
        .update_valid_i(update_valid),
        .update_i      (update)
    );

    bp_checker u_checker (
        .clk_i         (clk),
        .rst_i         (rst),
        .lookup_valid_i(lookup_valid),
        .lookup_i      (lookup),
        .lookup_ready_i(lookup_ready),
        .pred_valid_i  (pred_valid),
        .pred_i        (pred),
        .pred_ready_i  (pred_ready),
        .update_valid_i(update_valid),
        .update_i      (update),
        .test_i        (cur_test),
        .num_vectors_i (num_vec),
        .done_i        (done),
        .error_count_o (error_count),
        .pending_o     (pending),
        .timed_out_o   (timed_out)
    );

    // Falling edge, clears strobes and picks the consumer's ready
    task automatic next_cycle();
        @(negedge clk);
        lookup_valid = 1'b0;
        update_valid = 1'b0;
        if (stall_left > 0) begin
            pred_ready = 1'b0;
            stall_left--;
        end else begin
            pred_ready = (($random(seed) & 3) != 0);
        end
    endtask

    task automatic send_lookup(input logic [PC_W-1:0] pc);
        next_cycle();
        lookup_valid = 1'b1;
        lookup.pc = pc;
        #1;
        while (!lookup_ready) begin     // Hold the request until taken
            next_cycle();
            lookup_valid = 1'b1;
            #1;
        end
    endtask

    task automatic send_update(input logic [PC_W-1:0] pc, input logic taken,
                               input logic [PC_W-1:0] target);
        next_cycle();
        update_valid = 1'b1;
        update.pc = pc;
        update.taken = taken;
        update.target = target;
    endtask

    // Wait until every accepted lookup has its prediction back
    task automatic drain();
        next_cycle();
        while (pending != 0) begin
            next_cycle();
        end
    endtask

    task automatic run_vector(input logic [VEC_W-1:0] vec);
        logic [3:0]      op;
        logic [PC_W-1:0] pc;
        logic            taken;
        logic [PC_W-1:0] target;
        int              test_num;
        op = vec[79:76];
        pc = vec[75:44];
        taken = vec[40];
        target = vec[39:8];
        test_num = int'(vec[7:0]);
        if (test_num != cur_test) begin
            drain();
            cur_test = test_num;
        end
        case (op)
            4'd1: begin
                if (prev_update) begin
                    repeat (3) next_cycle();   // Let the table writes land
                end
                prev_update = 1'b0;
                send_lookup(pc);
            end
            4'd2: begin
                send_update(pc, taken, target);
                prev_update = 1'b1;
            end
            default: stall_left = int'(target);
        endcase
    endtask

    initial begin
        seed = 10;
        rst = 1'b1;
        lookup_valid = 1'b0;
        lookup = '0;
        pred_ready = 1'b0;
        update_valid = 1'b0;
        update = '0;
        stall_left = 0;
        cur_test = 0;
        prev_update = 1'b0;
        done = 1'b0;
        $readmemh("test/bp_vectors.txt", vec_mem);
        num_vec = 0;
        while (num_vec < MAX_VEC && vec_mem[num_vec][79:76] >= 4'd1
               && vec_mem[num_vec][79:76] <= 4'd3) begin
            num_vec++;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < num_vec; i++) begin
            run_vector(vec_mem[i]);
        end
        drain();
        done = 1'b1;
        @(negedge clk);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        wait (timed_out === 1'b1);
        $display("Test failed");
        $finish;
    end

endmodule

//--- test/bp_vectors.txt
// op_pc_outcome_target_test, op 1 lookup, 2 update, 3 stall
// A stall holds pred_ready low for the number of cycles in the target column
1_00001000_0_00000000_01
1_00002004_0_00000000_01
1_8000fffc_0_00000000_01
2_00000100_1_00000400_02
2_00000100_1_00000400_02
2_00000100_1_00000400_02
2_00000100_1_00000400_02
2_00000100_1_00000400_02
2_00000100_1_00000400_02
2_00000100_1_00000400_02
2_00000100_1_00000400_02
2_00000100_1_00000400_02
2_00000100_1_00000400_02
2_00000100_1_00000400_02
1_00000100_0_00000000_02
2_00000100_1_00000400_02
1_00000100_0_00000000_02
1_00000500_0_00000000_03
1_00000100_0_00000000_03
2_00000200_1_00000280_04
2_00000200_0_00000280_04
2_00000200_1_00000280_04
2_00000200_0_00000280_04
2_00000200_1_00000280_04
2_00000200_0_00000280_04
2_00000200_1_00000280_04
2_00000200_0_00000280_04
2_00000200_1_00000280_04
2_00000200_0_00000280_04
2_00000200_1_00000280_04
2_00000200_0_00000280_04
2_00000200_1_00000280_04
1_00000200_0_00000000_04
2_00000200_0_00000280_04
1_00000200_0_00000000_04
3_00000000_0_00000006_05
1_00000100_0_00000000_05
1_00000500_0_00000000_05
1_00000200_0_00000000_05

//--- filelist.f
src/bp_config_pkg.sv
src/bp_types_pkg.sv
src/bp_history_table.sv
src/bp_pattern_table.sv
src/bp_target_buffer.sv
src/bp_lookup_stage.sv
src/bp_update_stage.sv
src/branch_predictor.sv
test/bp_checker.sv
test/tb_branch_predictor.sv
